/* hdl/cache_pkg.sv */
/*
 * Shared widths, cache geometry and types for the Harvard cache subsystem.
 * Import into any module or interface that needs the word, address or
 * cache types.
 */
package cache_pkg;

    // Bus widths
    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 19;
    localparam int BYTESEL_W = 2;

    // Address split: tag 19..8, index 7..1
    localparam int INDEX_W   = 7;
    localparam int TAG_W     = ADDR_W - INDEX_W;
    localparam int NUM_LINES = 1 << INDEX_W;

    // One 16-bit data word
    typedef logic [WORD_W-1:0] word_t;

    // Word address, bits 19..1 of the byte address
    typedef logic [ADDR_W:1] waddr_t;

    // Byte enables, bit 1 high byte, bit 0 low byte
    typedef logic [BYTESEL_W-1:0] bytesel_t;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Cache controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        RESPOND
    } cache_state_t;

endpackage

/* hdl/mem_bus_if.sv */
/*
 * One access/ack memory bus. The master holds access with stable
 * address and data until a one-cycle ack; read data is valid with ack.
 * Read-only agents use the read_master and read_slave modports.
 */
`timescale 1ns/1ns

interface mem_bus_if
    import cache_pkg::*;
();

    // Master side
    waddr_t   addr;
    word_t    data_out;
    bytesel_t bytesel;
    logic     wr_en;
    logic     access;

    // Slave side
    word_t    data_in;
    logic     ack;

    modport master (
        output addr, data_out, bytesel, wr_en, access,
        input  data_in, ack
    );

    modport slave (
        input  addr, data_out, bytesel, wr_en, access,
        output data_in, ack
    );

    // Instruction side never writes
    modport read_master (
        output addr, access,
        input  data_in, ack
    );

    modport read_slave (
        input  addr, access,
        output data_in, ack
    );

endinterface

/* hdl/cache_arbiter.sv */
/*
 * Fixed-priority arbiter between the data and instruction caches for the
 * shared memory bus. The data cache wins a tie; the grant is registered
 * and released on the memory ack.
 */
`timescale 1ns/1ns

module cache_arbiter (
    input  logic           clk,
    input  logic           reset,
    mem_bus_if.read_slave  ibus,
    mem_bus_if.slave       dbus,
    mem_bus_if.master      mbus
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        SERVE_DCACHE,
        SERVE_ICACHE
    } arb_state_t;

    arb_state_t state;
    arb_state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ARB_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Requests are only sampled while idle
    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                if (dbus.access) begin
                    next_state = SERVE_DCACHE;
                end else if (ibus.access) begin
                    next_state = SERVE_ICACHE;
                end
            end
            SERVE_DCACHE: begin
                if (mbus.ack) begin
                    next_state = ARB_IDLE;
                end
            end
            SERVE_ICACHE: begin
                if (mbus.ack) begin
                    next_state = ARB_IDLE;
                end
            end
            default: begin
                next_state = ARB_IDLE;
            end
        endcase
    end

    // Route the granted cache onto the memory bus
    always_comb begin
        mbus.addr     = '0;
        mbus.data_out = '0;
        mbus.access   = 1'b0;
        mbus.wr_en    = 1'b0;
        mbus.bytesel  = 2'b11;
        dbus.ack      = 1'b0;
        ibus.ack      = 1'b0;

        case (state)
            SERVE_DCACHE: begin
                mbus.addr     = dbus.addr;
                mbus.data_out = dbus.data_out;
                mbus.access   = dbus.access;
                mbus.wr_en    = dbus.wr_en;
                mbus.bytesel  = dbus.bytesel;
                dbus.ack      = mbus.ack;
            end
            SERVE_ICACHE: begin
                // Fetches are always full-word reads
                mbus.addr     = ibus.addr;
                mbus.access   = ibus.access;
                mbus.wr_en    = 1'b0;
                mbus.bytesel  = 2'b11;
                ibus.ack      = mbus.ack;
            end
            default: begin
            end
        endcase
    end

    // Read data goes to both caches, only the acked one samples it
    assign dbus.data_in = mbus.data_in;
    assign ibus.data_in = mbus.data_in;

endmodule

/* hdl/icache.sv */
/*
 * Read-only direct-mapped instruction cache, one word per line.
 * Hits are acked two cycles after access; misses fetch the word over
 * the memory bus, fill the line and return it.
 */
`timescale 1ns/1ns

module icache
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  waddr_t          instr_addr,
    input  logic            instr_access,
    output word_t           instr_data,
    output logic            instr_ack,
    mem_bus_if.read_master  mbus
);

    cache_state_t state;
    cache_state_t next_state;

    waddr_t req_addr;
    word_t  rdata;
    tag_t   req_tag;
    index_t req_index;
    logic   hit;
    logic   fill;

    logic [NUM_LINES-1:0] valid;
    tag_t                 tag_ram  [NUM_LINES];
    word_t                data_ram [NUM_LINES];

    // Address split of the captured request
    assign req_tag   = req_addr[ADDR_W:INDEX_W+1];
    assign req_index = req_addr[INDEX_W:1];

    assign hit  = valid[req_index] && (tag_ram[req_index] == req_tag);
    assign fill = (state == MEM_WAIT) && mbus.ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (instr_access) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                next_state = hit ? RESPOND : MEM_WAIT;
            end
            MEM_WAIT: begin
                if (mbus.ack) begin
                    next_state = RESPOND;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[req_index] <= 1'b1;
        end
    end

    // Request capture, line fill and returned word
    always_ff @(posedge clk) begin
        if (state == IDLE && instr_access) begin
            req_addr <= instr_addr;
        end
        if (state == LOOKUP && hit) begin
            rdata <= data_ram[req_index];
        end
        if (fill) begin
            rdata               <= mbus.data_in;
            data_ram[req_index] <= mbus.data_in;
            tag_ram[req_index]  <= req_tag;
        end
    end

    assign instr_ack  = (state == RESPOND);
    assign instr_data = rdata;

    // Held until the edge that samples ack
    assign mbus.access = (state == MEM_WAIT);
    assign mbus.addr   = req_addr;

endmodule

/* hdl/dcache.sv */
/*
 * Direct-mapped write-through data cache without write allocate.
 * Reads behave like the instruction cache; every write goes to memory
 * and is merged into the line on a hit. The CPU ack follows the memory ack.
 */
`timescale 1ns/1ns

module dcache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  waddr_t      data_addr,
    input  word_t       data_wdata,
    input  logic        data_wr_en,
    input  bytesel_t    data_bytesel,
    input  logic        data_access,
    output word_t       data_rdata,
    output logic        data_ack,
    mem_bus_if.master   mbus
);

    cache_state_t state;
    cache_state_t next_state;

    waddr_t   req_addr;
    word_t    req_wdata;
    logic     req_wr;
    bytesel_t req_bytesel;
    word_t    rdata;
    tag_t     req_tag;
    index_t   req_index;
    logic     hit;
    logic     mem_done;

    logic [NUM_LINES-1:0] valid;
    tag_t                 tag_ram  [NUM_LINES];
    word_t                data_ram [NUM_LINES];

    // Replace only the enabled bytes of a word
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, bytesel_t sel);
        word_t merged;
        merged = old_word;
        if (sel[1]) begin
            merged[15:8] = new_word[15:8];
        end
        if (sel[0]) begin
            merged[7:0] = new_word[7:0];
        end
        return merged;
    endfunction

    assign req_tag   = req_addr[ADDR_W:INDEX_W+1];
    assign req_index = req_addr[INDEX_W:1];

    // Arrays are untouched while waiting, so the hit holds through MEM_WAIT
    assign hit      = valid[req_index] && (tag_ram[req_index] == req_tag);
    assign mem_done = (state == MEM_WAIT) && mbus.ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (data_access) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                // Writes always go through to memory
                if (!req_wr && hit) begin
                    next_state = RESPOND;
                end else begin
                    next_state = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (mbus.ack) begin
                    next_state = RESPOND;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Only a read miss allocates a line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else if (mem_done && !req_wr) begin
            valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && data_access) begin
            req_addr    <= data_addr;
            req_wdata   <= data_wdata;
            req_wr      <= data_wr_en;
            req_bytesel <= data_bytesel;
        end
        if (state == LOOKUP && !req_wr && hit) begin
            rdata <= data_ram[req_index];
        end
        if (mem_done) begin
            if (req_wr) begin
                if (hit) begin
                    data_ram[req_index] <= merge_bytes(data_ram[req_index], req_wdata,
                                                       req_bytesel);
                end
            end else begin
                rdata               <= mbus.data_in;
                data_ram[req_index] <= mbus.data_in;
                tag_ram[req_index]  <= req_tag;
            end
        end
    end

    assign data_ack   = (state == RESPOND);
    assign data_rdata = rdata;

    assign mbus.access   = (state == MEM_WAIT);
    assign mbus.addr     = req_addr;
    assign mbus.data_out = req_wdata;
    assign mbus.wr_en    = req_wr;
    // Read fills always fetch the whole word
    assign mbus.bytesel  = req_wr ? req_bytesel : 2'b11;

endmodule

/* hdl/harvard_cache_top.sv */
/*
 * Harvard cache subsystem top. Connects the CPU instruction and data
 * ports to their caches and puts the shared memory bus on plain ports
 * for an external SDRAM arbiter.
 */
`timescale 1ns/1ns

module harvard_cache_top
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // CPU instruction port
    input  waddr_t   instr_addr,
    input  logic     instr_access,
    output word_t    instr_data,
    output logic     instr_ack,

    // CPU data port
    input  waddr_t   data_addr,
    input  word_t    data_wdata,
    input  logic     data_wr_en,
    input  bytesel_t data_bytesel,
    input  logic     data_access,
    output word_t    data_rdata,
    output logic     data_ack,

    // External memory
    output waddr_t   mem_addr,
    output word_t    mem_data_out,
    input  word_t    mem_data_in,
    output logic     mem_access,
    input  logic     mem_ack,
    output logic     mem_wr_en,
    output bytesel_t mem_bytesel
);

    mem_bus_if ibus ();
    mem_bus_if dbus ();
    mem_bus_if mbus ();

    icache i_icache (
        .clk          (clk),
        .reset        (reset),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .mbus         (ibus.read_master)
    );

    dcache i_dcache (
        .clk          (clk),
        .reset        (reset),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_wr_en   (data_wr_en),
        .data_bytesel (data_bytesel),
        .data_access  (data_access),
        .data_rdata   (data_rdata),
        .data_ack     (data_ack),
        .mbus         (dbus.master)
    );

    cache_arbiter i_cache_arbiter (
        .clk   (clk),
        .reset (reset),
        .ibus  (ibus.read_slave),
        .dbus  (dbus.slave),
        .mbus  (mbus.master)
    );

    // Memory bus out to the plain ports
    assign mem_addr     = mbus.addr;
    assign mem_data_out = mbus.data_out;
    assign mem_access   = mbus.access;
    assign mem_wr_en    = mbus.wr_en;
    assign mem_bytesel  = mbus.bytesel;
    assign mbus.data_in = mem_data_in;
    assign mbus.ack     = mem_ack;

endmodule

/* dv/mem_model.sv */
/*
 * Memory responder for the testbench. Holds 4096 words that start from an
 * address pattern, answers each access after a random 0 to 7 cycle delay,
 * applies byte-select writes and counts accesses per word.
 */
`timescale 1ns/1ns

module mem_model
    import cache_pkg::*;
(
    input  logic     clk,
    input  waddr_t   addr,
    input  word_t    data_out,
    input  bytesel_t bytesel,
    input  logic     wr_en,
    input  logic     access,
    output word_t    data_in,
    output logic     ack
);

    word_t       mem [4096];
    int unsigned access_count [4096];
    logic [31:0] rand_state;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        int          delay;
        logic [11:0] a;
        data_in    = '0;
        ack        = 1'b0;
        rand_state = 32'h72ee2cda;
        for (int i = 0; i < 4096; i++) begin
            // Word pattern built from every address bit
            mem[i]          = {i[3:0], i[11:0]} ^ 16'h3c5a;
            access_count[i] = 0;
        end
        forever begin
            @(posedge clk);
            #1;
            if (access) begin
                rand_state = xorshift(rand_state);
                delay      = int'(rand_state[2:0]);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                a = addr[12:1];
                access_count[a] = access_count[a] + 1;
                if (wr_en) begin
                    if (bytesel[1]) begin
                        mem[a][15:8] = data_out[15:8];
                    end
                    if (bytesel[0]) begin
                        mem[a][7:0] = data_out[7:0];
                    end
                end else begin
                    data_in = mem[a];
                end
                // One-cycle ack pulse
                ack = 1'b1;
                @(posedge clk);
                #1;
                ack = 1'b0;
            end
        end
    end

endmodule

/* dv/harvard_cache_tb.sv */
/*
 * Testbench for the Harvard cache subsystem. Drives both CPU ports against
 * the memory model and checks data, hit or miss latency and memory traffic
 * against a shadow memory and shadow tag/valid copies of both caches.
 */
`timescale 1ns/1ns

module harvard_cache_tb
    import cache_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 100;

    typedef struct packed {
        waddr_t   addr;
        word_t    data;
        bytesel_t sel;
        logic     wr;
    } mem_txn_t;

    logic     clk;
    logic     reset;
    waddr_t   instr_addr;
    logic     instr_access;
    word_t    instr_data;
    logic     instr_ack;
    waddr_t   data_addr;
    word_t    data_wdata;
    logic     data_wr_en;
    bytesel_t data_bytesel;
    logic     data_access;
    word_t    data_rdata;
    logic     data_ack;
    waddr_t   mem_addr;
    word_t    mem_data_out;
    word_t    mem_data_in;
    logic     mem_access;
    logic     mem_ack;
    logic     mem_wr_en;
    bytesel_t mem_bytesel;

    // Reference model
    word_t                shadow_mem [4096];
    logic [NUM_LINES-1:0] ic_valid;
    logic [NUM_LINES-1:0] dc_valid;
    tag_t                 ic_tag [NUM_LINES];
    tag_t                 dc_tag [NUM_LINES];
    mem_txn_t             txn_log [$];

    logic [31:0] rand_state;
    logic        quiet_phase;
    int          errors;
    int          monitor_errors;

    harvard_cache_top i_harvard_cache_top (.*);

    mem_model i_mem (
        .clk      (clk),
        .addr     (mem_addr),
        .data_out (mem_data_out),
        .bytesel  (mem_bytesel),
        .wr_en    (mem_wr_en),
        .access   (mem_access),
        .data_in  (mem_data_in),
        .ack      (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Protocol checks and memory bus log at mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (quiet_phase) begin
                assert (!instr_ack && !data_ack && !mem_access) else begin
                    monitor_errors++;
                    $display("Error at %0t ns: ack or mem_access active before any request",
                             $time);
                end
            end
            assert (!instr_ack || instr_access) else begin
                monitor_errors++;
                $display("Error at %0t ns: instr_ack without a pending access", $time);
            end
            assert (!data_ack || data_access) else begin
                monitor_errors++;
                $display("Error at %0t ns: data_ack without a pending access", $time);
            end
            if (mem_access && mem_ack) begin
                txn_log.push_back({mem_addr, mem_data_out, mem_bytesel, mem_wr_en});
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = xorshift(rand_state);
        return rand_state;
    endfunction

    // Memory contents at reset are unique per word
    function automatic word_t pattern_word(input logic [11:0] a);
        return {a[3:0], a} ^ 16'h3c5a;
    endfunction

    function automatic word_t merge_word(input word_t old_word, input word_t new_word,
                                         input bytesel_t sel);
        return {sel[1] ? new_word[15:8] : old_word[15:8],
                sel[0] ? new_word[7:0] : old_word[7:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_last_write(input waddr_t addr, input word_t data, input bytesel_t sel);
        mem_txn_t last;
        last = txn_log[txn_log.size() - 1];
        check_value("mem_addr", 32'(addr), 32'(last.addr));
        check_value("mem_data_out", 32'(data), 32'(last.data));
        check_value("mem_bytesel", 32'(sel), 32'(last.sel));
        check_value("mem_wr_en", 32'd1, 32'(last.wr));
    endtask

    task automatic finish_run();
        $display("Errors: %0d in checks, %0d in protocol monitor", errors, monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        finish_run();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Called 1 ns after a rising edge; returns at the same point
    task automatic instr_read(input waddr_t addr);
        logic hit;
        int   lat;
        hit          = ic_valid[addr[7:1]] && (ic_tag[addr[7:1]] == addr[19:8]);
        instr_addr   = addr;
        instr_access = 1'b1;
        lat          = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT_CYCLES) begin
                report_timeout("instr_ack");
            end
        end while (!instr_ack);
        // A hit acks at the third falling edge and a miss takes longer
        check_value("instr_ack hit", 32'(hit), 32'(lat == 3));
        check_value("instr_data", 32'(shadow_mem[addr[12:1]]), 32'(instr_data));
        ic_valid[addr[7:1]] = 1'b1;
        ic_tag[addr[7:1]]   = addr[19:8];
        @(posedge clk);
        #1;
        instr_access = 1'b0;
    endtask

    task automatic data_op(input waddr_t addr, input logic wr, input word_t wdata,
                           input bytesel_t sel);
        logic hit;
        int   lat;
        hit          = dc_valid[addr[7:1]] && (dc_tag[addr[7:1]] == addr[19:8]);
        data_addr    = addr;
        data_wr_en   = wr;
        data_wdata   = wdata;
        data_bytesel = sel;
        data_access  = 1'b1;
        lat          = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT_CYCLES) begin
                report_timeout("data_ack");
            end
        end while (!data_ack);
        // Writes reach memory even on a hit
        check_value("data_ack hit", 32'(hit && !wr), 32'(lat == 3));
        if (wr) begin
            shadow_mem[addr[12:1]] = merge_word(shadow_mem[addr[12:1]], wdata, sel);
        end else begin
            check_value("data_rdata", 32'(shadow_mem[addr[12:1]]), 32'(data_rdata));
            dc_valid[addr[7:1]] = 1'b1;
            dc_tag[addr[7:1]]   = addr[19:8];
        end
        @(posedge clk);
        #1;
        data_access = 1'b0;
    endtask

    initial begin
        int          base;
        int unsigned count_a;
        logic [31:0] instr_draw [100];
        logic [31:0] data_draw  [100];
        rand_state   = 32'h72ee2cda;
        quiet_phase  = 1'b1;
        reset        = 1'b1;
        instr_addr   = '0;
        instr_access = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_wr_en   = 1'b0;
        data_bytesel = 2'b11;
        data_access  = 1'b0;
        ic_valid     = '0;
        dc_valid     = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow_mem[i] = pattern_word(12'(i));
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(5);
        quiet_phase = 1'b0;

        // Instruction miss then hit
        base = txn_log.size();
        instr_read(19'h00010);
        instr_read(19'h00010);
        check_value("mem transactions", 32'(base + 1), 32'(txn_log.size()));

        // Write hit and write miss with a read back of each
        data_op(19'h00805, 1'b0, 16'h0000, 2'b11);
        data_op(19'h00805, 1'b1, 16'habcd, 2'b10);
        check_last_write(19'h00805, 16'habcd, 2'b10);
        base = txn_log.size();
        data_op(19'h00805, 1'b0, 16'h0000, 2'b11);
        check_value("mem transactions", 32'(base), 32'(txn_log.size()));
        data_op(19'h00806, 1'b1, 16'h1234, 2'b01);
        check_last_write(19'h00806, 16'h1234, 2'b01);
        data_op(19'h00806, 1'b0, 16'h0000, 2'b11);

        // Simultaneous requests where the data cache goes first
        base = txn_log.size();
        fork
            instr_read(19'h00044);
            data_op(19'h00844, 1'b0, 16'h0000, 2'b11);
        join
        check_value("first mem_addr", 32'h844, 32'(txn_log[base].addr));

        // Same index with different tags
        base    = txn_log.size();
        count_a = i_mem.access_count[12'h020];
        instr_read(19'h00020);
        instr_read(19'h00120);
        instr_read(19'h00020);
        instr_read(19'h00120);
        check_value("mem transactions", 32'(base + 4), 32'(txn_log.size()));
        check_value("access count", 32'(count_a + 2), 32'(i_mem.access_count[12'h020]));
        base = txn_log.size();
        data_op(19'h00830, 1'b0, 16'h0000, 2'b11);
        data_op(19'h00930, 1'b0, 16'h0000, 2'b11);
        data_op(19'h00830, 1'b0, 16'h0000, 2'b11);
        data_op(19'h00930, 1'b1, 16'h5a5a, 2'b11);
        data_op(19'h00830, 1'b0, 16'h0000, 2'b11);
        data_op(19'h00930, 1'b0, 16'h0000, 2'b11);
        check_value("mem transactions", 32'(base + 5), 32'(txn_log.size()));

        // Each port gets its own fixed sequence of draws
        for (int n = 0; n < 100; n++) begin
            instr_draw[n] = next_rand();
            data_draw[n]  = next_rand();
        end

        // Random mix on both ports in disjoint address regions
        fork
            begin
                logic [31:0] r;
                for (int n = 0; n < 100; n++) begin
                    r = instr_draw[n];
                    idle_cycles(int'(r[25:24]));
                    instr_read(19'({3'b000, r[9:8], 3'b000, r[3:0]}));
                end
            end
            begin
                logic [31:0] r;
                for (int n = 0; n < 100; n++) begin
                    r = data_draw[n];
                    idle_cycles(int'(r[25:24]));
                    data_op(19'({3'b100, r[9:8], 3'b000, r[3:0]}), r[16], r[31:16], r[18:17]);
                end
            end
        join

        finish_run();
    end

endmodule

/* build.f */
hdl/cache_pkg.sv
hdl/mem_bus_if.sv
hdl/cache_arbiter.sv
hdl/icache.sv
hdl/dcache.sv
hdl/harvard_cache_top.sv
dv/mem_model.sv
dv/harvard_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Harvard cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ns \
    --top-module harvard_cache_tb \
    -f build.f \
    -o sim_harvard_cache

output=$(./obj_dir/sim_harvard_cache)
echo "$output"

if grep -q "^Simulation PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi
